/* dv/rv_core_checker.sv */
`timescale 1ns/1ns

module rv_core_checker (
    input logic        clk,
    input logic        rst_n,
    input logic [31:0] imem_addr,
    input logic        dmem_wen,
    input logic [3:0]  byte_en
);

    int fail_count = 0; // summed into the run summary

    write_has_lanes: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_wen |-> byte_en != 4'b0000)
        else begin
            fail_count++;
            $error("data memory write with no byte enabled");
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        imem_addr[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("instruction address not word aligned");
        end

    // pc holds on a stall, otherwise steps one word
    fetch_step: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (imem_addr == $past(imem_addr) ||
                          imem_addr == $past(imem_addr) + 32'd4))
        else begin
            fail_count++;
            $error("instruction address moved by other than 0 or 4");
        end

    quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !dmem_wen)
        else begin
            fail_count++;
            $error("data memory write right after reset");
        end

endmodule

bind rv_core rv_core_checker u_checker (
    .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr),
    .dmem_wen(dmem_wen), .byte_en(byte_en)
);

/* dv/rv_core_tb.sv */
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_core_tb;

    localparam int PROG_MAX   = 512;
    localparam int DMEM_WORDS = 256;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_insn;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        dmem_wen;
    logic [3:0]  byte_en;

    logic [31:0] prog [PROG_MAX];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] ref_mem [DMEM_WORDS];
    logic [31:0] exp_addr [$];
    logic [3:0]  exp_be [$];
    logic [31:0] exp_data [$];
    logic [31:0] rng = 32'd77;
    int          prog_len = 0;
    int          slot = 512;  // next word for saved results
    int          err_count = 0;
    int          store_count = 0;
    int          exp_total;
    int          end_addr;
    int          cycles;
    int          limit;

    tb_clock_gen clk_gen (.clk(clk), .rst_n(rst_n));

    rv_core UUT (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_insn(imem_insn),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
        .dmem_wen(dmem_wen), .byte_en(byte_en)
    );

    always_comb begin
        if (imem_addr[31:2] < prog_len) begin
            imem_insn = prog[imem_addr[10:2]];
        end else begin
            imem_insn = `RV_NOP_INSN; // past the program end
        end
    end

    always_comb begin
        if (dmem_addr < 4 * DMEM_WORDS) begin
            dmem_rdata = dmem[dmem_addr[9:2]];
        end else begin
            dmem_rdata = 32'h0;
        end
    end

    always @(posedge clk) begin
        if (dmem_wen === 1'b1) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    dmem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return (32'h9E37_79B9 * (idx + 1)) ^ 32'h5A5A_C3C3;
    endfunction

    function automatic logic [31:0] r_insn(input logic [2:0] f3, input logic alt,
                                          input logic [4:0] rd, rs1, rs2);
        return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_insn(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // stores always use x0 as base
    function automatic logic [31:0] s_insn(input logic [2:0] f3, input logic [4:0] rs2,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], rv_isa_pkg::OPC_STORE};
    endfunction

    task automatic put_insn(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic save_reg(input logic [4:0] rs);
        put_insn(s_insn(rv_isa_pkg::F3_SW, rs, 12'(slot)));
        slot = (slot == 764) ? 512 : slot + 4;
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // runs the program in order and lists every store it makes
    function automatic void ref_run();
        logic [31:0] regs [32];
        logic [31:0] insn;
        logic [31:0] a;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] val;
        logic [2:0]  f3;
        logic [3:0]  be;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            ref_mem[i] = fill_word(i);
        end
        for (int i = 0; i < prog_len; i++) begin
            insn  = prog[i];
            f3    = insn[14:12];
            a     = regs[insn[19:15]];
            imm_i = {{20{insn[31]}}, insn[31:20]};
            val   = regs[insn[11:7]]; // unchanged unless written below
            case (insn[6:0])
                7'b0110011: val = alu_ref(f3, insn[30], a, regs[insn[24:20]]);
                7'b0010011: val = alu_ref(f3, f3 == 3'd5 && insn[30], a, imm_i);
                7'b0000011: begin
                    addr = a + imm_i;
                    word = ref_mem[addr[9:2]] >> (8 * addr[1:0]);
                    case (f3)
                        3'd0: val = {{24{word[7]}}, word[7:0]};
                        3'd1: val = {{16{word[15]}}, word[15:0]};
                        3'd4: val = {24'd0, word[7:0]};
                        3'd5: val = {16'd0, word[15:0]};
                        default: val = word;
                    endcase
                end
                7'b0100011: begin
                    addr = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
                    be   = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
                    be   = be << addr[1:0];
                    word = regs[insn[24:20]] << (8 * addr[1:0]);
                    for (int b = 0; b < 4; b++) begin
                        if (be[b]) begin
                            ref_mem[addr[9:2]][8*b +: 8] = word[8*b +: 8];
                        end else begin
                            word[8*b +: 8] = 8'h00; // lane not written
                        end
                    end
                    exp_addr.push_back(addr);
                    exp_be.push_back(be);
                    exp_data.push_back(word);
                end
                default: ; // no-op
            endcase
            if (insn[11:7] != 5'd0) begin
                regs[insn[11:7]] = val;
            end
        end
    endfunction

    task automatic build_program();
        logic [2:0]  r_f3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
        logic        r_alt [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
        logic [2:0]  i_f3 [9] = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
        logic [2:0]  ld_f3 [5] = '{0, 1, 2, 4, 5};
        logic [31:0] r;
        logic [11:0] imm;
        logic [11:0] off;
        logic [2:0]  f3;
        put_insn(i_insn(rv_isa_pkg::OPC_LOAD, rv_isa_pkg::F3_LW, 1, 0, 12'd0));
        put_insn(i_insn(rv_isa_pkg::OPC_LOAD, rv_isa_pkg::F3_LW, 2, 0, 12'd4));
        put_insn(i_insn(rv_isa_pkg::OPC_LOAD, rv_isa_pkg::F3_LW, 3, 0, 12'd8));
        put_insn(i_insn(rv_isa_pkg::OPC_OP_IMM, 3'd0, 4, 0, 12'hB2E)); // -1234
        // each ALU op on independent operands
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < 10; k++) begin
                put_insn(r_insn(r_f3[k], r_alt[k], 5'(10 + k % 8), 5'(1 + 3 * p), 5'(2 + p)));
                save_reg(5'(10 + k % 8));
            end
            for (int k = 0; k < 9; k++) begin
                rng = xorshift(rng);
                imm = (k < 6) ? rng[11:0] : {1'b0, k == 8, 5'd0, rng[4:0]};
                put_insn(i_insn(rv_isa_pkg::OPC_OP_IMM, i_f3[k], 5'(10 + k % 8), 5'(3 + p), imm));
                save_reg(5'(10 + k % 8));
            end
        end
        // dependent chains
        put_insn(i_insn(rv_isa_pkg::OPC_OP_IMM, 3'd0, 5, 1, 12'd17));
        put_insn(r_insn(3'd0, 1'b0, 6, 5, 5));        // back to back
        put_insn(r_insn(3'd0, 1'b1, 7, 6, 1));
        put_insn(r_insn(3'd4, 1'b0, 8, 7, 6));
        put_insn(i_insn(rv_isa_pkg::OPC_OP_IMM, 3'd5, 9, 8, 12'h403)); // srai by 3
        save_reg(9);
        put_insn(i_insn(rv_isa_pkg::OPC_LOAD, rv_isa_pkg::F3_LW, 10, 0, 12'd12));
        put_insn(r_insn(3'd0, 1'b0, 11, 10, 10));     // load use
        save_reg(11);
        put_insn(i_insn(rv_isa_pkg::OPC_OP_IMM, 3'd0, 12, 2, 12'hFFB));
        put_insn(r_insn(3'd6, 1'b0, 13, 1, 3));
        put_insn(r_insn(3'd7, 1'b0, 14, 12, 2));      // distance two
        save_reg(14);
        put_insn(i_insn(rv_isa_pkg::OPC_OP_IMM, 3'd0, 0, 5, 12'd99)); // x0 stays zero
        put_insn(r_insn(3'd0, 1'b0, 15, 0, 5));
        save_reg(15);
        // top bit set in every byte: 0xFF87EAA5
        put_insn(i_insn(rv_isa_pkg::OPC_OP_IMM, 3'd0, 20, 0, 12'h87F));
        put_insn(i_insn(rv_isa_pkg::OPC_OP_IMM, 3'd1, 20, 20, 12'd12));
        put_insn(i_insn(rv_isa_pkg::OPC_OP_IMM, 3'd0, 20, 20, 12'hAA5));
        put_insn(s_insn(rv_isa_pkg::F3_SW, 20, 12'd256));
        for (int w = 256; w <= 260; w += 4) begin
            for (int k = 0; k < 4; k++) begin
                put_insn(i_insn(rv_isa_pkg::OPC_LOAD, rv_isa_pkg::F3_LB, 21, 0, 12'(w + k)));
                put_insn(i_insn(rv_isa_pkg::OPC_LOAD, rv_isa_pkg::F3_LBU, 22, 0, 12'(w + k)));
                save_reg(21);
                save_reg(22);
                if (k % 2 == 0) begin
                    put_insn(i_insn(rv_isa_pkg::OPC_LOAD, rv_isa_pkg::F3_LH, 23, 0, 12'(w + k)));
                    put_insn(i_insn(rv_isa_pkg::OPC_LOAD, rv_isa_pkg::F3_LHU, 24, 0, 12'(w + k)));
                    save_reg(23);
                    save_reg(24);
                end
            end
            put_insn(i_insn(rv_isa_pkg::OPC_LOAD, rv_isa_pkg::F3_LW, 25, 0, 12'(w)));
            save_reg(25);
        end
        // store widths at each aligned offset
        for (int k = 0; k < 4; k++) begin
            put_insn(s_insn(rv_isa_pkg::F3_SB, 1, 12'(768 + k)));
        end
        put_insn(s_insn(rv_isa_pkg::F3_SH, 2, 12'd772));
        put_insn(s_insn(rv_isa_pkg::F3_SH, 2, 12'd774));
        put_insn(s_insn(rv_isa_pkg::F3_SW, 3, 12'd776));
        put_insn(i_insn(rv_isa_pkg::OPC_LOAD, rv_isa_pkg::F3_LW, 26, 0, 12'd768));
        put_insn(i_insn(rv_isa_pkg::OPC_LOAD, rv_isa_pkg::F3_LW, 27, 0, 12'd772));
        save_reg(26);
        save_reg(27);
        for (int i = 0; i < 200; i++) begin
            rng = xorshift(rng);
            r   = rng;
            f3  = r[18:16];
            case (r % 11)
                0, 1, 2, 3: put_insn(r_insn(f3, (f3 == 3'd0 || f3 == 3'd5) && r[19],
                                            {1'b0, r[7:4]}, {1'b0, r[11:8]}, {1'b0, r[15:12]}));
                4, 5, 6: begin
                    if (f3 == 3'd1) begin
                        imm = {7'd0, r[24:20]};
                    end else if (f3 == 3'd5) begin
                        imm = {1'b0, r[19], 5'd0, r[24:20]};
                    end else begin
                        imm = r[31:20];
                    end
                    put_insn(i_insn(rv_isa_pkg::OPC_OP_IMM, f3, {1'b0, r[7:4]}, {1'b0, r[11:8]},
                                    imm));
                end
                7, 8: begin
                    f3  = ld_f3[r[3:0] % 5];
                    off = {2'b00, r[31:22]} & ~((12'd1 << f3[1:0]) - 12'd1); // aligned
                    put_insn(i_insn(rv_isa_pkg::OPC_LOAD, f3, {1'b0, r[7:4]}, 5'd0, off));
                end
                9: begin
                    f3  = 3'(r[3:0] % 3);
                    off = {2'b00, r[31:22]} & ~((12'd1 << f3[1:0]) - 12'd1);
                    put_insn(s_insn(f3, {1'b0, r[15:12]}, off));
                end
                default: put_insn({r[31:7], 7'b1100011}); // branch opcode, not supported
            endcase
        end
        for (int k = 1; k < 16; k++) begin
            save_reg(5'(k));
        end
    endtask

    task automatic log_mismatch(input string name, input logic [31:0] expv, gotv);
        $display("ERR %0t %s expected %h got %h", $time, name, expv, gotv);
        err_count++;
    endtask

    always @(posedge clk) begin : compare_stores
        logic [31:0] ea;
        logic [3:0]  eb;
        logic [31:0] ed;
        logic [31:0] mask;
        if (rst_n === 1'b1 && dmem_wen === 1'b1) begin
            store_count++;
            if (exp_addr.size() == 0) begin
                $display("store to %h at %0t is beyond the reference store list", dmem_addr,
                         $time);
                err_count++;
            end else begin
                ea   = exp_addr.pop_front();
                eb   = exp_be.pop_front();
                ed   = exp_data.pop_front();
                mask = {{8{eb[3]}}, {8{eb[2]}}, {8{eb[1]}}, {8{eb[0]}}};
                if (dmem_addr !== ea) begin
                    log_mismatch("dmem_addr", ea, dmem_addr);
                end
                if (byte_en !== eb) begin
                    log_mismatch("byte_en", 32'(eb), 32'(byte_en));
                end
                if ((dmem_wdata & mask) !== ed) begin
                    log_mismatch("dmem_wdata", ed, dmem_wdata & mask);
                end
            end
        end
    end

    initial begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = fill_word(i);
        end
        build_program();
        ref_run();
        exp_total = exp_addr.size();
        end_addr  = 4 * (prog_len + 4); // last insn past writeback
        limit     = prog_len * 3 + 20;
        cycles    = 0;
        wait (rst_n === 1'b1);
        if (imem_addr !== 32'd0) begin
            log_mismatch("imem_addr", 32'd0, imem_addr);
        end
        if (dmem_wen !== 1'b0) begin
            log_mismatch("dmem_wen", 32'd0, 32'(dmem_wen));
        end
        while (imem_addr < 32'(end_addr) && cycles <= limit) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles > limit) begin
            $display("timeout: program did not finish within %0d cycles", limit);
            err_count++;
        end else if (store_count != exp_total) begin
            $display("store count mismatch: the core wrote %0d stores, the reference %0d",
                     store_count, exp_total);
            err_count++;
        end
        $display("stores %0d of %0d, errors %0d, assertion failures %0d", store_count,
                 exp_total, err_count, UUT.u_checker.fail_count);
        if (err_count == 0 && UUT.u_checker.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int HALF_NS    = 4,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_NS clk = ~clk; // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // released on a falling edge
    end

endmodule

/* include/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// datapath and address width
`define RV_XLEN 32

`define RV_NREGS 32        // architectural registers
`define RV_REG_AW 5        // register index width

`define RV_INSN_STEP 32'd4 // pc increment per instruction

// addi x0, x0, 0
`define RV_NOP_INSN 32'h0000_0013

`endif

/* tb.f */
+incdir+include
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/rv_fetch.sv
verilog/rv_regfile.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_mem_wb.sv
verilog/rv_core.sv
dv/tb_clock_gen.sv
dv/rv_core_checker.sv
dv/rv_core_tb.sv

/* verilog/rv_core.sv */
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_core (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_insn,
    output logic [31:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    input  logic [31:0] dmem_rdata,
    output logic        dmem_wen,
    output logic [3:0]  byte_en
);

    logic [31:0]          insn;
    logic                 insn_valid;
    logic                 stall;
    logic [4:0]           rs1_addr;
    logic [4:0]           rs2_addr;
    logic [31:0]          rs1_data;
    logic [31:0]          rs2_data;
    logic [4:0]           ex_mem_rd;
    logic                 ex_mem_writes;
    logic                 wb_en;
    logic [4:0]           wb_rd;
    logic [31:0]          wb_data;
    rv_pipe_pkg::id_ex_t  id_ex;
    rv_pipe_pkg::ex_mem_t ex_mem;

    rv_fetch u_fetch (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .imem_insn(imem_insn), .imem_addr(imem_addr),
        .insn(insn), .insn_valid(insn_valid)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst_n(rst_n),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .wb_rd(wb_rd), .wb_en(wb_en), .wb_data(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv_decode u_decode (
        .clk(clk), .rst_n(rst_n), .insn(insn), .insn_valid(insn_valid),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_mem_rd(ex_mem_rd), .ex_mem_writes(ex_mem_writes),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .stall(stall), .id_ex(id_ex)
    );

    rv_execute u_execute (
        .clk(clk), .rst_n(rst_n), .id_ex(id_ex), .ex_mem(ex_mem),
        .ex_mem_rd(ex_mem_rd), .ex_mem_writes(ex_mem_writes)
    );

    rv_mem_wb u_mem_wb (
        .clk(clk), .rst_n(rst_n), .ex_mem(ex_mem), .dmem_rdata(dmem_rdata),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_wen(dmem_wen), .byte_en(byte_en),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
    );

endmodule

/* verilog/rv_decode.sv */
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [31:0]         insn,
    input  logic                insn_valid,
    input  logic [31:0]         rs1_data,
    input  logic [31:0]         rs2_data,
    input  logic [4:0]          ex_mem_rd,
    input  logic                ex_mem_writes,
    output logic [4:0]          rs1_addr,
    output logic [4:0]          rs2_addr,
    output logic                stall,
    output rv_pipe_pkg::id_ex_t id_ex
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] shamt_ext;
    logic                use_rs1;
    logic                use_rs2;
    logic                hit1;
    logic                hit2;
    logic                load_ok;
    logic                store_ok;
    rv_pipe_pkg::id_ex_t id_next;

    function automatic rv_isa_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        rv_isa_pkg::alu_op_e op;
        op = rv_isa_pkg::ALU_ADD;
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: op = alt ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     op = rv_isa_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     op = rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    op = rv_isa_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     op = rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: op = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      op = rv_isa_pkg::ALU_OR;
            rv_isa_pkg::F3_AND:     op = rv_isa_pkg::ALU_AND;
            default:                op = rv_isa_pkg::ALU_ADD;
        endcase
        return op;
    endfunction

    assign opcode    = insn[6:0];
    assign funct3    = insn[14:12];
    assign rd        = insn[11:7];
    assign rs1_addr  = insn[19:15];
    assign rs2_addr  = insn[24:20];
    assign imm_i     = {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};
    assign imm_s     = {{(`RV_XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
    assign shamt_ext = {{(`RV_XLEN-5){1'b0}}, insn[24:20]};

    assign load_ok  = funct3 inside {rv_isa_pkg::F3_LB, rv_isa_pkg::F3_LH, rv_isa_pkg::F3_LW,
                                     rv_isa_pkg::F3_LBU, rv_isa_pkg::F3_LHU};
    assign store_ok = funct3 inside {rv_isa_pkg::F3_SB, rv_isa_pkg::F3_SH, rv_isa_pkg::F3_SW};

    // only real source fields count, the imm bits of I-type are not rs2
    assign use_rs1 = opcode inside {rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM,
                                    rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_STORE};
    assign use_rs2 = opcode inside {rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_STORE};

    // pending writer in execute or in memory
    assign hit1 = (rs1_addr != '0) &&
                  ((id_ex.valid && id_ex.reg_write && id_ex.rd == rs1_addr) ||
                   (ex_mem_writes && ex_mem_rd == rs1_addr));
    assign hit2 = (rs2_addr != '0) &&
                  ((id_ex.valid && id_ex.reg_write && id_ex.rd == rs2_addr) ||
                   (ex_mem_writes && ex_mem_rd == rs2_addr));

    assign stall = insn_valid && ((use_rs1 && hit1) || (use_rs2 && hit2));

    always_comb begin
        id_next           = '0;
        id_next.valid     = insn_valid && !stall; // bubble while stalled
        id_next.funct3    = funct3;
        id_next.rd        = rd;
        id_next.opa       = rs1_data;
        id_next.opb       = rs2_data;
        id_next.store_val = rs2_data;
        id_next.alu_op    = rv_isa_pkg::ALU_ADD;
        id_next.mem_op    = rv_pipe_pkg::MEM_NONE;
        id_next.reg_write = 1'b0;
        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                id_next.reg_write = 1'b1;
                id_next.alu_op    = alu_sel(funct3, insn[rv_isa_pkg::FUNCT7_ALT_BIT]);
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                id_next.reg_write = 1'b1;
                // alt bit only matters for srai, addi keeps its imm bit
                id_next.alu_op    = alu_sel(funct3, funct3 == rv_isa_pkg::F3_SRL_SRA &&
                                            insn[rv_isa_pkg::FUNCT7_ALT_BIT]);
                if (funct3 == rv_isa_pkg::F3_SLL || funct3 == rv_isa_pkg::F3_SRL_SRA) begin
                    id_next.opb = shamt_ext;
                end else begin
                    id_next.opb = imm_i;
                end
            end
            rv_isa_pkg::OPC_LOAD: begin
                id_next.reg_write = load_ok;
                id_next.mem_op    = load_ok ? rv_pipe_pkg::MEM_LOAD : rv_pipe_pkg::MEM_NONE;
                id_next.opb       = imm_i;
            end
            rv_isa_pkg::OPC_STORE: begin
                id_next.mem_op = store_ok ? rv_pipe_pkg::MEM_STORE : rv_pipe_pkg::MEM_NONE;
                id_next.opb    = imm_s;
            end
            default: ; // anything else passes as a no-op
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex <= id_next;
        end
    end

endmodule

/* verilog/rv_execute.sv */
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_execute (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_pipe_pkg::id_ex_t  id_ex,
    output rv_pipe_pkg::ex_mem_t ex_mem,
    output logic [4:0]           ex_mem_rd,
    output logic                 ex_mem_writes
);

    logic [`RV_XLEN-1:0]  alu_out;
    logic [4:0]           shamt;
    logic [1:0]           lane;
    logic [3:0]           base_en;
    logic                 lt_s;
    logic                 lt_u;
    rv_pipe_pkg::ex_mem_t ex_next;

    assign shamt = id_ex.opb[4:0];
    assign lt_s  = $signed(id_ex.opa) < $signed(id_ex.opb);
    assign lt_u  = id_ex.opa < id_ex.opb;

    always_comb begin
        case (id_ex.alu_op)
            rv_isa_pkg::ALU_ADD:  alu_out = id_ex.opa + id_ex.opb; // also load/store address
            rv_isa_pkg::ALU_SUB:  alu_out = id_ex.opa - id_ex.opb;
            rv_isa_pkg::ALU_SLL:  alu_out = id_ex.opa << shamt;
            rv_isa_pkg::ALU_SLT:  alu_out = {{(`RV_XLEN-1){1'b0}}, lt_s};
            rv_isa_pkg::ALU_SLTU: alu_out = {{(`RV_XLEN-1){1'b0}}, lt_u};
            rv_isa_pkg::ALU_XOR:  alu_out = id_ex.opa ^ id_ex.opb;
            rv_isa_pkg::ALU_SRL:  alu_out = id_ex.opa >> shamt;
            rv_isa_pkg::ALU_SRA:  alu_out = $unsigned($signed(id_ex.opa) >>> shamt);
            rv_isa_pkg::ALU_OR:   alu_out = id_ex.opa | id_ex.opb;
            rv_isa_pkg::ALU_AND:  alu_out = id_ex.opa & id_ex.opb;
            default:              alu_out = id_ex.opa + id_ex.opb;
        endcase
    end

    assign lane = alu_out[1:0]; // byte offset within the word

    always_comb begin
        case (id_ex.funct3)
            rv_isa_pkg::F3_SB: base_en = 4'b0001;
            rv_isa_pkg::F3_SH: base_en = 4'b0011;
            rv_isa_pkg::F3_SW: base_en = 4'b1111;
            default:           base_en = 4'b0000;
        endcase
    end

    always_comb begin
        ex_next.valid      = id_ex.valid;
        ex_next.mem_op     = id_ex.mem_op;
        ex_next.funct3     = id_ex.funct3;
        ex_next.rd         = id_ex.rd;
        ex_next.reg_write  = id_ex.reg_write;
        ex_next.result     = alu_out;
        ex_next.store_data = id_ex.store_val << {lane, 3'b000}; // move into addressed lanes
        if (id_ex.mem_op == rv_pipe_pkg::MEM_STORE) begin
            ex_next.byte_en = base_en << lane;
        end else begin
            ex_next.byte_en = 4'b0000;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem <= ex_next;
        end
    end

    // destination of the instruction now in memory access
    assign ex_mem_rd     = ex_mem.rd;
    assign ex_mem_writes = ex_mem.valid && ex_mem.reg_write;

endmodule

/* verilog/rv_fetch.sv */
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_fetch (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic [31:0] imem_insn,
    output logic [31:0] imem_addr,
    output logic [31:0] insn,
    output logic        insn_valid
);

    logic [`RV_XLEN-1:0] pc;

    assign imem_addr = pc; // memory answers in the same cycle

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc         <= '0;
            insn       <= `RV_NOP_INSN;
            insn_valid <= 1'b0;
        end else if (!stall) begin
            pc         <= pc + `RV_INSN_STEP;
            insn       <= imem_insn;
            insn_valid <= 1'b1;
        end
        // on a stall pc and insn hold, so the same word is refetched
    end

endmodule

/* verilog/rv_isa_pkg.sv */
`include "rv_params.svh"

package rv_isa_pkg;

    typedef logic [`RV_REG_AW-1:0] reg_idx_t; // rs1, rs2 and rd fields

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } opcode_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    localparam int FUNCT7_ALT_BIT = 30; // sub / sra select

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

endpackage

/* verilog/rv_mem_wb.sv */
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_mem_wb (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_pipe_pkg::ex_mem_t ex_mem,
    input  logic [31:0]          dmem_rdata,
    output logic [31:0]          dmem_addr,
    output logic [31:0]          dmem_wdata,
    output logic                 dmem_wen,
    output logic [3:0]           byte_en,
    output logic                 wb_en,
    output logic [4:0]           wb_rd,
    output logic [31:0]          wb_data
);

    logic [`RV_XLEN-1:0]  rd_shift;
    logic [`RV_XLEN-1:0]  load_val;
    rv_pipe_pkg::mem_wb_t mem_wb;

    assign dmem_addr  = ex_mem.result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_wen   = ex_mem.valid && (ex_mem.mem_op == rv_pipe_pkg::MEM_STORE);
    assign byte_en    = dmem_wen ? ex_mem.byte_en : 4'b0000;

    assign rd_shift = dmem_rdata >> {ex_mem.result[1:0], 3'b000}; // addressed byte to bit 0

    always_comb begin
        case (ex_mem.funct3)
            rv_isa_pkg::F3_LB:  load_val = {{(`RV_XLEN-8){rd_shift[7]}}, rd_shift[7:0]};
            rv_isa_pkg::F3_LH:  load_val = {{(`RV_XLEN-16){rd_shift[15]}}, rd_shift[15:0]};
            rv_isa_pkg::F3_LW:  load_val = dmem_rdata;
            rv_isa_pkg::F3_LBU: load_val = {{(`RV_XLEN-8){1'b0}}, rd_shift[7:0]};
            rv_isa_pkg::F3_LHU: load_val = {{(`RV_XLEN-16){1'b0}}, rd_shift[15:0]};
            default:            load_val = dmem_rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.reg_write <= ex_mem.reg_write;
            if (ex_mem.mem_op == rv_pipe_pkg::MEM_LOAD) begin
                mem_wb.value <= load_val;
            end else begin
                mem_wb.value <= ex_mem.result;
            end
        end
    end

    assign wb_en   = mem_wb.valid && mem_wb.reg_write; // regfile drops x0
    assign wb_rd   = mem_wb.rd;
    assign wb_data = mem_wb.value;

endmodule

/* verilog/rv_pipe_pkg.sv */
`include "rv_params.svh"

package rv_pipe_pkg;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    // decode to execute
    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::alu_op_e   alu_op;
        mem_op_e               mem_op;
        logic [2:0]            funct3;    // load / store width
        rv_isa_pkg::reg_idx_t  rd;
        logic                  reg_write;
        logic [`RV_XLEN-1:0]   opa;
        logic [`RV_XLEN-1:0]   opb;       // rs2, imm or shamt
        logic [`RV_XLEN-1:0]   store_val;
    } id_ex_t;

    // execute to memory
    typedef struct packed {
        logic                  valid;
        mem_op_e               mem_op;
        logic [2:0]            funct3;
        rv_isa_pkg::reg_idx_t  rd;
        logic                  reg_write;
        logic [`RV_XLEN-1:0]   result;     // alu result or address
        logic [`RV_XLEN-1:0]   store_data; // already in byte lanes
        logic [3:0]            byte_en;
    } ex_mem_t;

    // memory to writeback
    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::reg_idx_t  rd;
        logic                  reg_write;
        logic [`RV_XLEN-1:0]   value;
    } mem_wb_t;

endpackage

/* verilog/rv_regfile.sv */
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic [4:0]  wb_rd,
    input  logic        wb_en,
    input  logic [31:0] wb_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic                wr_live;

    assign wr_live = wb_en && (wb_rd != '0); // x0 stays zero

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // same-cycle write reaches the reader directly
    assign rs1_data = (wr_live && wb_rd == rs1_addr) ? wb_data : regs[rs1_addr];
    assign rs2_data = (wr_live && wb_rd == rs2_addr) ? wb_data : regs[rs2_addr];

endmodule
